// File: project.f
+incdir+include
verilog/lcd_pkg.sv
verilog/tick_divider.sv
verilog/button_sync.sv
verilog/lcd_bus_writer.sv
verilog/display_sequencer.sv
verilog/hex_display.sv
verilog/board_top.sv
verif/lcd_bus_monitor.sv
verif/board_top_tb.sv

// File: Makefile
# Verilator simulation of the panel controller board top level

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = board_top_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/board_top_tb.sv
`include "lcd_settings.svh"

module board_top_tb;

  // button presses driven in one run
  localparam int num_presses = 12;
  // command plus pixel bytes per accepted press
  localparam int burst_len = `LCD_FILL_BYTES + 1;
  // one write in the worst tick phase plus margin
  localparam int write_cycles = 5 * `LCD_DIV_COUNT + 4;
  // longest gap plus hold and release around one press
  localparam int press_cycles = 31 + 12;
  localparam int max_writes = `LCD_INIT_LEN + num_presses * burst_len;
  localparam int watchdog_cycles =
    2 * (max_writes * write_cycles + num_presses * press_cycles) + 200;

  logic        hwclk;
  logic        reset;
  logic [20:0] pb;
  logic [7:0]  left;
  logic [7:0]  right;
  logic [7:0]  ss7;
  logic [7:0]  ss6;
  logic [7:0]  ss5;
  logic [7:0]  ss4;
  logic [7:0]  ss3;
  logic [7:0]  ss2;
  logic [7:0]  ss1;
  logic [7:0]  ss0;
  logic        red;
  logic        green;
  logic        blue;

  // monitor outputs
  logic               seen;
  logic               seen_dc;
  lcd_pkg::lcd_byte_t seen_byte;
  logic               cycle_end;
  logic               rdx_fault;
  logic               csx_fault;

  // expected writes as {dcx, byte}
  logic [8:0]  exp_q [$];
  int          checked;
  int          expected_total;
  int          accepted;
  int          dropped;
  logic [31:0] lfsr_state;

  board_top board_top_i (
    .hwclk (hwclk),
    .reset (reset),
    .pb    (pb),
    .left  (left),
    .right (right),
    .ss7   (ss7),
    .ss6   (ss6),
    .ss5   (ss5),
    .ss4   (ss4),
    .ss3   (ss3),
    .ss2   (ss2),
    .ss1   (ss1),
    .ss0   (ss0),
    .red   (red),
    .green (green),
    .blue  (blue)
  );

  lcd_bus_monitor lcd_bus_monitor_i (
    .hwclk     (hwclk),
    .reset     (reset),
    .left      (left),
    .right     (right),
    .seen      (seen),
    .seen_dc   (seen_dc),
    .seen_byte (seen_byte),
    .cycle_end (cycle_end),
    .rdx_fault (rdx_fault),
    .csx_fault (csx_fault)
  );

  initial begin
    hwclk = 1'b0;
    forever #5 hwclk = ~hwclk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "run stopped at the first error");
  endtask

  // galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    lfsr_next = state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  // one lfsr step per bit taken
  task automatic draw_bits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
  endtask

  // active high gfedcba back to a hex digit with the dot off
  function automatic int seg_to_hex(input logic [7:0] seg);
    case (seg)
      8'h3F: seg_to_hex = 0;
      8'h06: seg_to_hex = 1;
      8'h5B: seg_to_hex = 2;
      8'h4F: seg_to_hex = 3;
      8'h66: seg_to_hex = 4;
      8'h6D: seg_to_hex = 5;
      8'h7D: seg_to_hex = 6;
      8'h07: seg_to_hex = 7;
      8'h7F: seg_to_hex = 8;
      8'h6F: seg_to_hex = 9;
      8'h77: seg_to_hex = 10;
      8'h7C: seg_to_hex = 11;
      8'h39: seg_to_hex = 12;
      8'h5E: seg_to_hex = 13;
      8'h79: seg_to_hex = 14;
      8'h71: seg_to_hex = 15;
      default: seg_to_hex = -1;
    endcase
  endfunction

  task automatic check_digits(input int count);
    logic [7:0]  segs [8];
    logic [31:0] value;
    int          digit;
    segs[0] = ss0;
    segs[1] = ss1;
    segs[2] = ss2;
    segs[3] = ss3;
    segs[4] = ss4;
    segs[5] = ss5;
    segs[6] = ss6;
    segs[7] = ss7;
    value = count;
    // ss0 holds the low nibble
    for (int i = 0; i < 8; i++) begin
      digit = seg_to_hex(segs[i]);
      assert (digit == int'(value[4*i +: 4])) else
        report_failure($sformatf("Error: %0t ss%0d shows %h, expected digit %h of count %0d",
                                 $time, i, segs[i], value[4*i +: 4], count));
    end
  endtask

  // next expected write against the captured one
  task automatic check_write();
    logic [8:0] expected;
    assert (exp_q.size() != 0) else
      report_failure($sformatf("Error: %0t unexpected write dcx=%b data=%h",
                               $time, seen_dc, seen_byte));
    expected = exp_q.pop_front();
    assert ({seen_dc, seen_byte} == expected) else
      report_failure($sformatf("Error: %0t write %0d dcx=%b data=%h, expected dcx=%b data=%h",
                               $time, checked, seen_dc, seen_byte, expected[8], expected[7:0]));
    // init done only after the last table entry
    if (checked < `LCD_INIT_LEN) begin
      assert (!green) else
        report_failure($sformatf("Error: %0t green high during init write %0d", $time, checked));
    end
    checked++;
  endtask

  // command entries carry dcx low
  task automatic load_init_model();
    exp_q.push_back({1'b0, 8'h01});
    exp_q.push_back({1'b0, 8'h11});
    exp_q.push_back({1'b0, 8'h3A});
    exp_q.push_back({1'b1, 8'h55});
    exp_q.push_back({1'b0, 8'h29});
    expected_total += `LCD_INIT_LEN;
  endtask

  task automatic press_button(input lcd_pkg::lcd_byte_t colour);
    pb[15:8] = colour;
    pb[0]    = 1'b1;
    // blue rises with the synced level
    // red at that edge is what the FSM sees
    @(negedge hwclk);
    while (!blue) @(negedge hwclk);
    if (!red) begin
      exp_q.push_back({1'b0, 8'h2C});
      for (int i = 0; i < `LCD_FILL_BYTES; i++) begin
        exp_q.push_back({1'b1, colour});
      end
      expected_total += burst_len;
      accepted++;
    end else begin
      dropped++;
    end
    repeat (2) @(negedge hwclk);
    pb[0] = 1'b0;
    // let the low level reach the edge detector
    repeat (2) @(negedge hwclk);
    assert (!blue) else
      report_failure($sformatf("Error: %0t blue=%b two cycles after button release",
                               $time, blue));
  endtask

  // pin checks on stable values
  always @(negedge hwclk) begin
    if (!reset) begin
      if (seen) begin
        check_write();
      end
      // counter follows wr_done by one cycle
      if (cycle_end) begin
        check_digits(checked);
      end
      assert (!rdx_fault) else
        report_failure($sformatf("rdx went low at %0t on a write only bus", $time));
      assert (!csx_fault) else
        report_failure($sformatf("csx rose while wrx was low at %0t", $time));
      assert (left[7:4] == 4'h0) else
        report_failure($sformatf("Error: %0t left[7:4]=%b, expected 0000", $time, left[7:4]));
    end
  end

  initial begin
    logic [31:0]        bits;
    logic               wait_idle;
    int                 gap;
    lcd_pkg::lcd_byte_t colour;
    reset          = 1'b1;
    pb             = '0;
    checked        = 0;
    expected_total = 0;
    accepted       = 0;
    dropped        = 0;
    lfsr_state     = 32'hbb1423e8;
    load_init_model();
    repeat (3) @(negedge hwclk);
    reset = 1'b0;

    // strobes idle high and count zero before the first write
    assert (left == 8'h0F && right == 8'h00) else
      report_failure($sformatf("Error: %0t after reset left=%b right=%h", $time, left, right));
    assert (!green && !red) else
      report_failure($sformatf("Error: %0t after reset green=%b red=%b", $time, green, red));
    check_digits(0);

    // green only once the whole table went out
    while (!green) @(negedge hwclk);
    assert (checked == `LCD_INIT_LEN) else
      report_failure($sformatf("Error: %0t green rose after %0d writes", $time, checked));

    for (int p = 0; p < num_presses; p++) begin
      draw_bits(1, bits);
      wait_idle = bits[0];
      draw_bits(5, bits);
      gap = int'(bits[4:0]);
      draw_bits(8, bits);
      colour = bits[7:0];
      // mix presses on an idle FSM with presses into a burst
      if (wait_idle) begin
        while (red) @(negedge hwclk);
      end
      repeat (gap) @(negedge hwclk);
      press_button(colour);
    end

    // drain the last burst and watch for stray writes
    repeat (4) @(negedge hwclk);
    while (red || exp_q.size() != 0) @(negedge hwclk);
    repeat (8 * `LCD_DIV_COUNT) @(negedge hwclk);

    assert (accepted > 0) else
      report_failure("no press was accepted, so no pixel burst was checked");
    check_digits(expected_total);
    $display("presses accepted %0d, dropped %0d, writes checked %0d",
             accepted, dropped, checked);
    $display("=== PASS ===");
    $finish;
  end

  // hung run guard
  initial begin
    repeat (watchdog_cycles) @(posedge hwclk);
    report_failure($sformatf("Timeout: run did not finish within %0d hwclk cycles",
                             watchdog_cycles));
  end

endmodule

// File: verif/lcd_bus_monitor.sv
module lcd_bus_monitor (
  input  logic               hwclk,
  input  logic               reset,
  input  logic [7:0]         left,
  input  logic [7:0]         right,
  output logic               seen,
  output logic               seen_dc,
  output lcd_pkg::lcd_byte_t seen_byte,
  output logic               cycle_end,
  output logic               rdx_fault,
  output logic               csx_fault
);

  // strobes as they sit on the header pins
  logic wrx;
  logic rdx;
  logic csx;
  logic dcx;
  // strobe levels one hwclk earlier
  logic wrx_q;
  logic csx_q;
  // panel latch point
  logic wrx_rise;

  assign wrx = left[3];
  assign rdx = left[2];
  assign csx = left[1];
  assign dcx = left[0];

  // rising wrx while the panel is selected
  assign wrx_rise = ~wrx_q & wrx & ~csx;

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      wrx_q     <= 1'b1;
      csx_q     <= 1'b1;
      seen      <= 1'b0;
      seen_dc   <= 1'b0;
      seen_byte <= '0;
      cycle_end <= 1'b0;
      rdx_fault <= 1'b0;
      csx_fault <= 1'b0;
    end else begin
      wrx_q <= wrx;
      csx_q <= csx;
      // one pulse per completed write, dc and data captured with it
      seen  <= wrx_rise;
      if (wrx_rise) begin
        seen_dc   <= dcx;
        seen_byte <= right;
      end
      // deselect ends the bus cycle
      cycle_end <= ~csx_q & csx;
      // write only bus
      rdx_fault <= ~rdx;
      // deselect in the middle of a wrx low pulse
      csx_fault <= ~csx_q & csx & ~wrx;
    end
  end

endmodule

// File: verilog/board_top.sv
module board_top (
  input  logic        hwclk,
  input  logic        reset,
  input  logic [20:0] pb,
  output logic [7:0]  left,
  output logic [7:0]  right,
  output logic [7:0]  ss7,
  output logic [7:0]  ss6,
  output logic [7:0]  ss5,
  output logic [7:0]  ss4,
  output logic [7:0]  ss3,
  output logic [7:0]  ss2,
  output logic [7:0]  ss1,
  output logic [7:0]  ss0,
  output logic        red,
  output logic        green,
  output logic        blue
);

  logic               tick;
  logic               fill_press;
  lcd_pkg::lcd_byte_t colour;
  logic               button_level;

  logic               wr_start;
  logic               wr_dc;
  lcd_pkg::lcd_byte_t wr_byte;
  logic               wr_done;

  // panel strobes
  logic wrx;
  logic rdx;
  logic csx;
  logic dcx;

  // bus pacing
  tick_divider tick_divider_i (
    .hwclk (hwclk),
    .reset (reset),
    .tick  (tick)
  );

  button_sync button_sync_i (
    .hwclk        (hwclk),
    .reset        (reset),
    .pb           (pb),
    .fill_press   (fill_press),
    .colour       (colour),
    .button_level (button_level)
  );

  display_sequencer display_sequencer_i (
    .hwclk      (hwclk),
    .reset      (reset),
    .fill_press (fill_press),
    .colour     (colour),
    .wr_done    (wr_done),
    .wr_start   (wr_start),
    .wr_dc      (wr_dc),
    .wr_byte    (wr_byte),
    .busy       (red),
    .init_done  (green)
  );

  // data goes straight out on right
  lcd_bus_writer lcd_bus_writer_i (
    .hwclk    (hwclk),
    .reset    (reset),
    .tick     (tick),
    .wr_start (wr_start),
    .wr_dc    (wr_dc),
    .wr_byte  (wr_byte),
    .wr_done  (wr_done),
    .lcd_data (right),
    .lcd_wrx  (wrx),
    .lcd_rdx  (rdx),
    .lcd_csx  (csx),
    .lcd_dcx  (dcx)
  );

  // running write count in hex
  hex_display hex_display_i (
    .hwclk   (hwclk),
    .reset   (reset),
    .wr_done (wr_done),
    .ss7     (ss7),
    .ss6     (ss6),
    .ss5     (ss5),
    .ss4     (ss4),
    .ss3     (ss3),
    .ss2     (ss2),
    .ss1     (ss1),
    .ss0     (ss0)
  );

  // strobes on the low header pins
  assign left = {4'b0000, wrx, rdx, csx, dcx};

  assign blue = button_level;

endmodule

// File: verilog/hex_display.sv
module hex_display (
  input  logic               hwclk,
  input  logic               reset,
  input  logic               wr_done,
  output lcd_pkg::lcd_byte_t ss7,
  output lcd_pkg::lcd_byte_t ss6,
  output lcd_pkg::lcd_byte_t ss5,
  output lcd_pkg::lcd_byte_t ss4,
  output lcd_pkg::lcd_byte_t ss3,
  output lcd_pkg::lcd_byte_t ss2,
  output lcd_pkg::lcd_byte_t ss1,
  output lcd_pkg::lcd_byte_t ss0
);

  lcd_pkg::lcd_count_t count;

  // active high segments gfedcba
  function automatic logic [6:0] seg_decode(input lcd_pkg::lcd_nibble_t digit);
    case (digit)
      4'h0: seg_decode = 7'h3F;
      4'h1: seg_decode = 7'h06;
      4'h2: seg_decode = 7'h5B;
      4'h3: seg_decode = 7'h4F;
      4'h4: seg_decode = 7'h66;
      4'h5: seg_decode = 7'h6D;
      4'h6: seg_decode = 7'h7D;
      4'h7: seg_decode = 7'h07;
      4'h8: seg_decode = 7'h7F;
      4'h9: seg_decode = 7'h6F;
      4'hA: seg_decode = 7'h77;
      4'hB: seg_decode = 7'h7C;
      4'hC: seg_decode = 7'h39;
      4'hD: seg_decode = 7'h5E;
      4'hE: seg_decode = 7'h79;
      default: seg_decode = 7'h71;
    endcase
  endfunction

  // one count per completed bus write
  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      count <= '0;
    end else if (wr_done) begin
      count <= count + 1'b1;
    end
  end

  // decimal point unused, top nibble on ss7
  assign ss7 = {1'b0, seg_decode(count[31:28])};
  assign ss6 = {1'b0, seg_decode(count[27:24])};
  assign ss5 = {1'b0, seg_decode(count[23:20])};
  assign ss4 = {1'b0, seg_decode(count[19:16])};
  assign ss3 = {1'b0, seg_decode(count[15:12])};
  assign ss2 = {1'b0, seg_decode(count[11:8])};
  assign ss1 = {1'b0, seg_decode(count[7:4])};
  assign ss0 = {1'b0, seg_decode(count[3:0])};

endmodule

// File: verilog/display_sequencer.sv
`include "lcd_settings.svh"

module display_sequencer (
  input  logic               hwclk,
  input  logic               reset,
  input  logic               fill_press,
  input  lcd_pkg::lcd_byte_t colour,
  input  logic               wr_done,
  output logic               wr_start,
  output logic               wr_dc,
  output lcd_pkg::lcd_byte_t wr_byte,
  output logic               busy,
  output logic               init_done
);

  localparam int idx_w = (`LCD_INIT_LEN > 1) ? $clog2(`LCD_INIT_LEN) : 1;
  localparam int fill_w = (`LCD_FILL_BYTES > 1) ? $clog2(`LCD_FILL_BYTES) : 1;
  localparam logic [idx_w-1:0] idx_last = idx_w'(`LCD_INIT_LEN - 1);
  localparam logic [fill_w-1:0] fill_last = fill_w'(`LCD_FILL_BYTES - 1);

  lcd_pkg::seq_state_t state;
  lcd_pkg::seq_state_t state_n;

  // position in the init table
  logic [idx_w-1:0]   init_idx;
  // pixel bytes already sent in this burst
  logic [fill_w-1:0]  fill_cnt;
  // colour captured at the press
  lcd_pkg::lcd_byte_t fill_colour;

  logic               init_dc;
  lcd_pkg::lcd_byte_t init_byte;

  // panel init table
  always_comb begin
    case (init_idx)
      // software reset
      idx_w'(0): begin
        init_dc   = `LCD_DC_CMD;
        init_byte = 8'h01;
      end
      // sleep out
      idx_w'(1): begin
        init_dc   = `LCD_DC_CMD;
        init_byte = 8'h11;
      end
      // pixel format
      idx_w'(2): begin
        init_dc   = `LCD_DC_CMD;
        init_byte = 8'h3A;
      end
      // 16 bit per pixel
      idx_w'(3): begin
        init_dc   = `LCD_DC_DATA;
        init_byte = 8'h55;
      end
      // display on
      default: begin
        init_dc   = `LCD_DC_CMD;
        init_byte = 8'h29;
      end
    endcase
  end

  // next state
  always_comb begin
    state_n = state;
    case (state)
      lcd_pkg::seq_init:       state_n = lcd_pkg::seq_wait_init;
      lcd_pkg::seq_wait_init: begin
        if (wr_done) begin
          state_n = (init_idx == idx_last) ? lcd_pkg::seq_idle : lcd_pkg::seq_init;
        end
      end
      // presses outside idle are dropped
      lcd_pkg::seq_idle: begin
        if (fill_press) begin
          state_n = lcd_pkg::seq_cmd;
        end
      end
      lcd_pkg::seq_cmd:        state_n = lcd_pkg::seq_wait_cmd;
      lcd_pkg::seq_wait_cmd: begin
        if (wr_done) begin
          state_n = lcd_pkg::seq_pixel;
        end
      end
      lcd_pkg::seq_pixel:      state_n = lcd_pkg::seq_wait_pixel;
      lcd_pkg::seq_wait_pixel: begin
        if (wr_done) begin
          state_n = (fill_cnt == fill_last) ? lcd_pkg::seq_idle : lcd_pkg::seq_pixel;
        end
      end
      default:                 state_n = lcd_pkg::seq_init;
    endcase
  end

  // state register with table index and burst counter
  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      state     <= lcd_pkg::seq_init;
      init_idx  <= '0;
      fill_cnt  <= '0;
      init_done <= 1'b0;
      busy      <= 1'b0;
    end else begin
      state <= state_n;
      // low in reset, then high in every state but idle
      busy  <= (state_n != lcd_pkg::seq_idle);
      if (state == lcd_pkg::seq_wait_init && wr_done) begin
        if (init_idx == idx_last) begin
          init_done <= 1'b1;
        end else begin
          init_idx <= init_idx + 1'b1;
        end
      end
      if (state == lcd_pkg::seq_wait_cmd && wr_done) begin
        fill_cnt <= '0;
      end
      if (state == lcd_pkg::seq_wait_pixel && wr_done) begin
        fill_cnt <= fill_cnt + 1'b1;
      end
    end
  end

  // colour held for the whole burst
  always_ff @(posedge hwclk) begin
    if (state == lcd_pkg::seq_idle && fill_press) begin
      fill_colour <= colour;
    end
  end

  // one cycle strobe from each issue state
  assign wr_start = (state == lcd_pkg::seq_init) || (state == lcd_pkg::seq_cmd) ||
                    (state == lcd_pkg::seq_pixel);

  always_comb begin
    case (state)
      lcd_pkg::seq_init: begin
        wr_dc   = init_dc;
        wr_byte = init_byte;
      end
      lcd_pkg::seq_cmd: begin
        wr_dc   = `LCD_DC_CMD;
        wr_byte = `LCD_CMD_RAMWR;
      end
      default: begin
        wr_dc   = `LCD_DC_DATA;
        wr_byte = fill_colour;
      end
    endcase
  end

endmodule

// File: verilog/lcd_bus_writer.sv
module lcd_bus_writer (
  input  logic               hwclk,
  input  logic               reset,
  input  logic               tick,
  input  logic               wr_start,
  input  logic               wr_dc,
  input  lcd_pkg::lcd_byte_t wr_byte,
  output logic               wr_done,
  output lcd_pkg::lcd_byte_t lcd_data,
  output logic               lcd_wrx,
  output logic               lcd_rdx,
  output logic               lcd_csx,
  output logic               lcd_dcx
);

  lcd_pkg::wr_phase_t phase;

  // captured byte and dc for the cycle in flight
  lcd_pkg::lcd_byte_t byte_q;
  logic               dc_q;
  // start seen, waiting for the first tick
  logic               pend;

  // capture on the start strobe
  always_ff @(posedge hwclk) begin
    if (wr_start) begin
      byte_q <= wr_byte;
      dc_q   <= wr_dc;
    end
  end

  // one phase per tick
  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      phase    <= lcd_pkg::wr_idle;
      pend     <= 1'b0;
      wr_done  <= 1'b0;
      lcd_csx  <= 1'b1;
      lcd_wrx  <= 1'b1;
      lcd_dcx  <= 1'b1;
      lcd_data <= '0;
    end else begin
      wr_done <= 1'b0;
      if (wr_start) begin
        pend <= 1'b1;
      end
      case (phase)
        lcd_pkg::wr_idle: begin
          // select the panel and present dc and data
          if (pend && tick) begin
            pend     <= 1'b0;
            phase    <= lcd_pkg::wr_setup;
            lcd_csx  <= 1'b0;
            lcd_dcx  <= dc_q;
            lcd_data <= byte_q;
          end
        end
        lcd_pkg::wr_setup: begin
          if (tick) begin
            phase   <= lcd_pkg::wr_low;
            lcd_wrx <= 1'b0;
          end
        end
        lcd_pkg::wr_low: begin
          // panel latches on this rising edge of wrx
          if (tick) begin
            phase   <= lcd_pkg::wr_high;
            lcd_wrx <= 1'b1;
          end
        end
        lcd_pkg::wr_high: begin
          // release chip select, data stays on the bus
          if (tick) begin
            phase   <= lcd_pkg::wr_idle;
            lcd_csx <= 1'b1;
            wr_done <= 1'b1;
          end
        end
        default: begin
          phase <= lcd_pkg::wr_idle;
        end
      endcase
    end
  end

  // write only bus, no read cycle
  assign lcd_rdx = 1'b1;

endmodule

// File: verilog/button_sync.sv
module button_sync (
  input  logic              hwclk,
  input  logic              reset,
  input  logic [20:0]       pb,
  output logic              fill_press,
  output lcd_pkg::lcd_byte_t colour,
  output logic              button_level
);

  // bit 0 is the fill button, bits 8:1 carry the colour switches
  logic [8:0] sync_a;
  logic [8:0] sync_b;
  // previous synchronized button level
  logic       level_q;

  // two flop chain into the hwclk domain
  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      sync_a  <= '0;
      sync_b  <= '0;
      level_q <= 1'b0;
    end else begin
      sync_a  <= {pb[15:8], pb[0]};
      sync_b  <= sync_a;
      level_q <= sync_b[0];
    end
  end

  // rising edge of the clean button level
  assign fill_press = sync_b[0] & ~level_q;

  // colour as seen after synchronization
  assign colour = sync_b[8:1];

  // raw level for the board LED
  assign button_level = sync_b[0];

endmodule

// File: verilog/tick_divider.sv
`include "lcd_settings.svh"

module tick_divider (
  input  logic hwclk,
  input  logic reset,
  output logic tick
);

  // counter wide enough for the divide ratio
  localparam int cnt_w = (`LCD_DIV_COUNT > 1) ? $clog2(`LCD_DIV_COUNT) : 1;
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`LCD_DIV_COUNT - 1);

  logic [cnt_w-1:0] count;

  // free running count, tick on the wrap cycle
  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      count <= '0;
      tick  <= 1'b0;
    end else begin
      if (count == cnt_last) begin
        count <= '0;
        tick  <= 1'b1;
      end else begin
        count <= count + 1'b1;
        // single cycle pulse only
        tick  <= 1'b0;
      end
    end
  end

endmodule

// File: verilog/lcd_pkg.sv
package lcd_pkg;

  // one byte on the parallel panel bus
  typedef logic [7:0] lcd_byte_t;

  // completed write count, one nibble per digit
  typedef logic [31:0] lcd_count_t;

  // single hex digit
  typedef logic [3:0] lcd_nibble_t;

  // control sequencer states
  typedef enum logic [2:0] {
    seq_init,
    seq_wait_init,
    seq_idle,
    seq_cmd,
    seq_wait_cmd,
    seq_pixel,
    seq_wait_pixel
  } seq_state_t;

  // phases of one 8080 write cycle
  typedef enum logic [1:0] {
    wr_idle,
    wr_setup,
    wr_low,
    wr_high
  } wr_phase_t;

endpackage

// File: include/lcd_settings.svh
`ifndef LCD_SETTINGS_SVH
`define LCD_SETTINGS_SVH

// hwclk cycles per bus tick
// small for simulation, raise for the board
`define LCD_DIV_COUNT 4

// pixel bytes sent per button press
`define LCD_FILL_BYTES 6

// entries in the panel init table
`define LCD_INIT_LEN 5

// memory write command that opens a pixel burst
`define LCD_CMD_RAMWR 8'h2C

// dcx levels on the 8080 bus
`define LCD_DC_CMD 1'b0
`define LCD_DC_DATA 1'b1

`endif
